// ==== logic/fetch_params.svh ====
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// pc width in bits
`define FETCH_XLEN 64

// first fetch address after reset
`define FETCH_RESET_PC 64'h0000_0000_8000_0000

// itcm word address width, 16384 words
`define ITCM_AW 14

// queue and stack depths as log2
`define BHQ_AW 4
`define RAS_AW 4
`define IFQ_AW 3

`endif

// ==== logic/fetch_pkg.sv ====
`default_nettype none

`include "fetch_params.svh"

package fetch_pkg;

	// program counter
	typedef logic [`FETCH_XLEN-1:0] pc_t;

	// one 32-bit instruction word, no compressed forms
	typedef logic [31:0] instr_t;

	// itcm word address
	typedef logic [`ITCM_AW-1:0] itcm_addr_t;

	// one prediction in the branch history queue
	// alt_pc is the path that fetch did not follow
	typedef struct packed {
		logic taken;
		pc_t alt_pc;
	} branch_rec_t;

	// entry handed to the decoder
	typedef struct packed {
		pc_t pc;
		instr_t instr;
	} fetch_entry_t;

endpackage

`default_nettype wire

// ==== logic/sync_fifo.sv ====
`default_nettype none

module sync_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int AW = 4
) (
	input wire logic CLK,
	input wire logic rst_n,
	input wire logic flush,
	input wire logic push,
	input wire logic pop,
	input wire payload_t data_push,
	output payload_t data_pop,
	output logic empty,
	output logic full
);

	localparam int DEPTH = 2 ** AW;

	payload_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count;
	logic do_push;
	logic do_pop;

	// count tops out at DEPTH, so the msb alone marks full
	assign empty = (count == '0);
	assign full = count[AW];

	// a pop frees the head slot in the same cycle
	assign do_push = push && (!full || pop);
	assign do_pop = pop && !empty;

	assign data_pop = mem[rd_ptr];

	always_ff @(posedge CLK) begin
		if (do_push) begin
			mem[wr_ptr] <= data_push;
		end
	end

	always_ff @(posedge CLK) begin
		if (!rst_n || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// producer must hold off while full unless the head leaves too
	assert property (@(posedge CLK) disable iff (!rst_n) (push && full) |-> pop);

	assert property (@(posedge CLK) disable iff (!rst_n) pop |-> !empty);

endmodule

`default_nettype wire

// ==== logic/return_stack.sv ====
`default_nettype none

module return_stack #(
	parameter int AW = 4
) (
	input wire logic CLK,
	input wire logic rst_n,
	input wire logic push,
	input wire logic pop,
	input wire fetch_pkg::pc_t data_push,
	output fetch_pkg::pc_t data_pop,
	output logic empty
);

	import fetch_pkg::*;

	localparam int DEPTH = 2 ** AW;

	pc_t ring [DEPTH];
	logic [AW-1:0] top_ptr;
	logic [AW:0] count;

	assign empty = (count == '0);
	assign data_pop = ring[top_ptr];

	// push and pop together replace the top in place
	// a plain push past capacity lands on the oldest slot
	always_ff @(posedge CLK) begin
		if (push) begin
			if (pop) begin
				ring[top_ptr] <= data_push;
			end else begin
				ring[top_ptr + 1'b1] <= data_push;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			top_ptr <= '0;
			count <= '0;
		end else if (push && !pop) begin
			top_ptr <= top_ptr + 1'b1;
			// saturate at DEPTH, older entries are simply lost
			if (!count[AW]) begin
				count <= count + 1'b1;
			end
		end else if (pop && !push) begin
			top_ptr <= top_ptr - 1'b1;
			count <= count - 1'b1;
		end
	end

	assert property (@(posedge CLK) disable iff (!rst_n) pop |-> !empty);

endmodule

`default_nettype wire

// ==== logic/itcm.sv ====
`default_nettype none

`include "fetch_params.svh"

module itcm (
	input wire logic CLK,
	input wire fetch_pkg::itcm_addr_t addr,
	input wire logic we,
	input wire fetch_pkg::instr_t wdata,
	output fetch_pkg::instr_t rdata
);

	import fetch_pkg::*;

	localparam int DEPTH = 2 ** `ITCM_AW;

	instr_t mem [DEPTH];

	// single port, one cycle from address to data
	always_ff @(posedge CLK) begin
		if (we) begin
			mem[addr] <= wdata;
		end
	end

	// read returns the old word when written in the same cycle
	always_ff @(posedge CLK) begin
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

// ==== logic/itcm_arbiter.sv ====
`default_nettype none

`include "fetch_params.svh"

module itcm_arbiter (
	input wire logic load_we,
	input wire fetch_pkg::itcm_addr_t load_addr,
	input wire fetch_pkg::instr_t load_data,
	input wire fetch_pkg::pc_t fetch_addr,
	output logic fetch_grant,
	output fetch_pkg::itcm_addr_t mem_addr,
	output logic mem_we,
	output fetch_pkg::instr_t mem_wdata
);

	// loader always wins, fetch only reads
	assign fetch_grant = !load_we;
	assign mem_we = load_we;
	assign mem_wdata = load_data;

	// fetch pc is byte based, the itcm is word addressed
	assign mem_addr = load_we ? load_addr : fetch_addr[2 +: `ITCM_AW];

endmodule

`default_nettype wire

// ==== logic/pc_generate.sv ====
`default_nettype none

`include "fetch_params.svh"

module pc_generate (
	input wire logic CLK,
	input wire logic rst_n,

	input wire fetch_pkg::instr_t rd_data,
	input wire logic fetch_grant,
	output fetch_pkg::pc_t fetch_addr,

	input wire logic jalr_valid,
	input wire fetch_pkg::pc_t jalr_pc,

	input wire logic bru_valid,
	input wire logic bru_taken,
	output logic mispredict,

	input wire logic ifq_full,
	output logic ifq_push,
	output fetch_pkg::fetch_entry_t ifq_data,
	output logic ifq_flush,

	input wire logic bhq_full,
	output logic bhq_push,
	output fetch_pkg::branch_rec_t bhq_data_push,
	input wire fetch_pkg::branch_rec_t bhq_data_pop,

	input wire logic ras_empty,
	input wire fetch_pkg::pc_t ras_top,
	output logic ras_push,
	output logic ras_pop,
	output fetch_pkg::pc_t ras_data_push
);

	import fetch_pkg::*;

	localparam logic [6:0] OP_JAL = 7'b1101111;
	localparam logic [6:0] OP_JALR = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;

	pc_t pc_q;
	pc_t fetch_pc_dnxt;
	logic instr_valid;

	logic [4:0] rd;
	logic [4:0] rs1;
	logic is_jal;
	logic is_jalr;
	logic is_branch;
	logic is_call;
	logic is_return;
	logic use_ras;

	pc_t imm;
	pc_t pc_inc;
	pc_t target;
	logic pred_taken;
	logic stall;
	logic advance;

	logic [`BHQ_AW:0] bhq_cnt;

	// predecode, just enough to find control flow
	assign rd = rd_data[11:7];
	assign rs1 = rd_data[19:15];
	assign is_jal = (rd_data[6:0] == OP_JAL);
	assign is_jalr = (rd_data[6:0] == OP_JALR);
	assign is_branch = (rd_data[6:0] == OP_BRANCH);

	// link registers are x1 and x5
	assign is_call = (is_jal || is_jalr) && (rd == 5'd1 || rd == 5'd5);
	assign is_return = is_jalr && (rs1 == 5'd1 || rs1 == 5'd5) && (rs1 != rd);
	assign use_ras = is_return && !ras_empty;

	// j-type or b-type immediate, sign extended
	assign imm = is_jal ?
		{{(`FETCH_XLEN-20){rd_data[31]}}, rd_data[19:12], rd_data[20],
			rd_data[30:21], 1'b0} :
		{{(`FETCH_XLEN-12){rd_data[31]}}, rd_data[7], rd_data[30:25],
			rd_data[11:8], 1'b0};

	assign pc_inc = pc_q + `FETCH_XLEN'd4;

	always_comb begin
		if (is_jal || is_branch) begin
			target = pc_q + imm;
		end else if (use_ras) begin
			target = ras_top;
		end else begin
			target = jalr_pc;
		end
	end

	// static rule: jumps and backward branches taken
	assign pred_taken = is_jal || is_jalr || (is_branch && imm[`FETCH_XLEN-1]);

	assign stall = !instr_valid
		|| !fetch_grant
		|| ifq_full
		|| (is_branch && bhq_full)
		|| (is_jalr && !use_ras && !jalr_valid);

	assign mispredict = bru_valid && (bru_taken != bhq_data_pop.taken);
	assign advance = !stall && !mispredict;

	always_comb begin
		if (mispredict) begin
			fetch_pc_dnxt = bhq_data_pop.alt_pc;
		end else if (advance) begin
			fetch_pc_dnxt = pred_taken ? target : pc_inc;
		end else begin
			fetch_pc_dnxt = pc_q;
		end
	end

	assign fetch_addr = fetch_pc_dnxt;

	// the word read this cycle belongs to fetch_pc_dnxt
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			pc_q <= `FETCH_RESET_PC;
			instr_valid <= 1'b0;
		end else begin
			pc_q <= fetch_pc_dnxt;
			instr_valid <= fetch_grant && !mispredict;
		end
	end

	assign ifq_push = advance;
	assign ifq_data = '{pc: pc_q, instr: rd_data};
	assign ifq_flush = mispredict;

	assign bhq_push = advance && is_branch;
	assign bhq_data_push = '{taken: pred_taken, alt_pc: pred_taken ? pc_inc : target};

	// a jalr can be both return and call, the stack swaps its top
	assign ras_push = advance && is_call;
	assign ras_pop = advance && use_ras;
	assign ras_data_push = pc_inc;

	// shadow count of unresolved branches
	always_ff @(posedge CLK) begin
		if (!rst_n || mispredict) begin
			bhq_cnt <= '0;
		end else begin
			case ({bhq_push, bru_valid})
				2'b10: bhq_cnt <= bhq_cnt + 1'b1;
				2'b01: bhq_cnt <= bhq_cnt - 1'b1;
				default: bhq_cnt <= bhq_cnt;
			endcase
		end
	end

	// resolution only for branches fetch has recorded
	assert property (@(posedge CLK) disable iff (!rst_n) bru_valid |-> (bhq_cnt != '0));

endmodule

`default_nettype wire

// ==== logic/fetch_unit.sv ====
`default_nettype none

`include "fetch_params.svh"

module fetch_unit (
	input wire logic CLK,
	input wire logic rst_n,
	input wire logic load_we,
	input wire fetch_pkg::itcm_addr_t load_addr,
	input wire fetch_pkg::instr_t load_data,
	input wire logic jalr_valid,
	input wire fetch_pkg::pc_t jalr_pc,
	input wire logic bru_valid,
	input wire logic bru_taken,
	output logic mispredict,
	input wire logic ifq_pop,
	output logic ifq_valid,
	output fetch_pkg::pc_t ifq_pc,
	output fetch_pkg::instr_t ifq_instr
);

	import fetch_pkg::*;

	pc_t fetch_addr;
	logic fetch_grant;
	itcm_addr_t mem_addr;
	logic mem_we;
	instr_t mem_wdata;
	instr_t rd_data;

	logic ifq_full;
	logic ifq_empty;
	logic ifq_push;
	logic ifq_flush;
	fetch_entry_t ifq_data;
	fetch_entry_t ifq_head;

	logic bhq_full;
	logic bhq_push;
	branch_rec_t bhq_data_push;
	branch_rec_t bhq_data_pop;

	logic ras_empty;
	logic ras_push;
	logic ras_pop;
	pc_t ras_top;
	pc_t ras_data_push;

	assign ifq_valid = !ifq_empty;
	assign ifq_pc = ifq_head.pc;
	assign ifq_instr = ifq_head.instr;

	itcm_arbiter u_arb (
		.load_we(load_we),
		.load_addr(load_addr),
		.load_data(load_data),
		.fetch_addr(fetch_addr),
		.fetch_grant(fetch_grant),
		.mem_addr(mem_addr),
		.mem_we(mem_we),
		.mem_wdata(mem_wdata)
	);

	itcm u_itcm (
		.CLK(CLK),
		.addr(mem_addr),
		.we(mem_we),
		.wdata(mem_wdata),
		.rdata(rd_data)
	);

	pc_generate u_pcgen (
		.CLK(CLK),
		.rst_n(rst_n),
		.rd_data(rd_data),
		.fetch_grant(fetch_grant),
		.fetch_addr(fetch_addr),
		.jalr_valid(jalr_valid),
		.jalr_pc(jalr_pc),
		.bru_valid(bru_valid),
		.bru_taken(bru_taken),
		.mispredict(mispredict),
		.ifq_full(ifq_full),
		.ifq_push(ifq_push),
		.ifq_data(ifq_data),
		.ifq_flush(ifq_flush),
		.bhq_full(bhq_full),
		.bhq_push(bhq_push),
		.bhq_data_push(bhq_data_push),
		.bhq_data_pop(bhq_data_pop),
		.ras_empty(ras_empty),
		.ras_top(ras_top),
		.ras_push(ras_push),
		.ras_pop(ras_pop),
		.ras_data_push(ras_data_push)
	);

	return_stack #(
		.AW(`RAS_AW)
	) u_ras (
		.CLK(CLK),
		.rst_n(rst_n),
		.push(ras_push),
		.pop(ras_pop),
		.data_push(ras_data_push),
		.data_pop(ras_top),
		.empty(ras_empty)
	);

	// every resolution retires the oldest record
	sync_fifo #(
		.payload_t(branch_rec_t),
		.AW(`BHQ_AW)
	) u_bhq (
		.CLK(CLK),
		.rst_n(rst_n),
		.flush(mispredict),
		.push(bhq_push),
		.pop(bru_valid),
		.data_push(bhq_data_push),
		.data_pop(bhq_data_pop),
		.empty(),
		.full(bhq_full)
	);

	sync_fifo #(
		.payload_t(fetch_entry_t),
		.AW(`IFQ_AW)
	) u_ifq (
		.CLK(CLK),
		.rst_n(rst_n),
		.flush(ifq_flush),
		.push(ifq_push),
		.pop(ifq_pop && ifq_valid),
		.data_push(ifq_data),
		.data_pop(ifq_head),
		.empty(ifq_empty),
		.full(ifq_full)
	);

endmodule

`default_nettype wire

// ==== verif/fetch_unit_tb.sv ====
`default_nettype none

`include "fetch_params.svh"

module fetch_unit_tb;

	import fetch_pkg::*;

	localparam int N_ROWS = 6;
	localparam int MAX_POPS = 64;
	localparam pc_t RESET_PC = `FETCH_RESET_PC;

	logic CLK;
	logic rst_n;
	logic load_we;
	itcm_addr_t load_addr;
	instr_t load_data;
	logic jalr_valid;
	pc_t jalr_pc;
	logic bru_valid;
	logic bru_taken;
	logic mispredict;
	logic ifq_pop;
	logic ifq_valid;
	pc_t ifq_pc;
	instr_t ifq_instr;

	// stimulus table, one row per test
	string row_name [N_ROWS];
	instr_t prog [N_ROWS][8];
	int n_pops [N_ROWS];
	bit ev_given [N_ROWS][8];
	bit ev_taken [N_ROWS][8];
	pc_t row_jalr_pc [N_ROWS];
	bit stress [N_ROWS];
	bit hold_bru [N_ROWS];

	// expected pop stream of the current row
	pc_t exp_pc [MAX_POPS];
	instr_t exp_instr [MAX_POPS];
	bit exp_is_br [MAX_POPS];
	bit exp_taken [MAX_POPS];
	bit exp_mis [MAX_POPS];

	bit pending [$];
	int cycles;
	int limit;

	fetch_unit u_dut (
		.CLK(CLK),
		.rst_n(rst_n),
		.load_we(load_we),
		.load_addr(load_addr),
		.load_data(load_data),
		.jalr_valid(jalr_valid),
		.jalr_pc(jalr_pc),
		.bru_valid(bru_valid),
		.bru_taken(bru_taken),
		.mispredict(mispredict),
		.ifq_pop(ifq_pop),
		.ifq_valid(ifq_valid),
		.ifq_pc(ifq_pc),
		.ifq_instr(ifq_instr)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("timeout, the popped stream stopped before the expected end");
			$display("TEST FAILED");
			$fatal(1);
		end
	end

	task automatic check_pc(input string name, input pc_t exp, input pc_t act);
		if (exp !== act) begin
			$display("mismatch %s pc expected %h actual %h", name, exp, act);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_instr(input string name, input instr_t exp, input instr_t act);
		if (exp !== act) begin
			$display("mismatch %s instr expected %h actual %h", name, exp, act);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_mispredict(input string name, input bit exp, input bit act);
		if (exp !== act) begin
			$display("mismatch %s mispredict expected %0b actual %0b", name, exp, act);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	// b-type and j-type offsets from the base isa encoding
	function automatic pc_t branch_offset(input instr_t i);
		logic [12:0] o;
		o = {i[31], i[7], i[30:25], i[11:8], 1'b0};
		return {{(`FETCH_XLEN-13){o[12]}}, o};
	endfunction

	function automatic pc_t jump_offset(input instr_t i);
		logic [20:0] o;
		o = {i[31], i[19:12], i[20], i[30:21], 1'b0};
		return {{(`FETCH_XLEN-21){o[20]}}, o};
	endfunction

	function automatic bit is_link(input logic [4:0] r);
		return (r == 5'd1) || (r == 5'd5);
	endfunction

	task automatic fill_table();
		for (int r = 0; r < N_ROWS; r++) begin
			for (int w = 0; w < 8; w++) begin
				prog[r][w] = 32'h0000_0013;
				ev_given[r][w] = 1'b0;
				ev_taken[r][w] = 1'b0;
			end
			prog[r][7] = 32'h0000_006f;
			row_jalr_pc[r] = RESET_PC;
			stress[r] = 1'b0;
			hold_bru[r] = 1'b0;
		end
		row_name[0] = "sequential";
		n_pops[0] = 12;
		// forward beq, jal over a word, backward beq loop
		row_name[1] = "static_prediction";
		prog[1][1] = 32'h0000_0463;
		prog[1][2] = 32'h0080_006f;
		prog[1][5] = 32'hfe00_0ce3;
		n_pops[1] = 14;
		// jal x1 to a return, then an indirect jalr through x10
		row_name[2] = "call_return";
		prog[2][0] = 32'h00c0_00ef;
		prog[2][2] = 32'h0005_0067;
		prog[2][4] = 32'h0000_8067;
		row_jalr_pc[2] = RESET_PC + 64'h18;
		n_pops[2] = 10;
		row_name[3] = "mispredict";
		prog[3][0] = 32'h0000_0463;
		prog[3][3] = 32'hfe00_0ce3;
		prog[3][5] = 32'h0000_0463;
		ev_given[3][0] = 1'b1;
		ev_taken[3][0] = 1'b1;
		ev_given[3][1] = 1'b1;
		ev_taken[3][1] = 1'b0;
		n_pops[3] = 10;
		row_name[4] = "backpressure";
		prog[4] = prog[1];
		stress[4] = 1'b1;
		n_pops[4] = 40;
		// two-word loop, resolutions held back until the queue fills
		row_name[5] = "bhq_full";
		prog[5][1] = 32'hfe00_0ee3;
		hold_bru[5] = 1'b1;
		n_pops[5] = 60;
		limit = 200;
		for (int r = 0; r < N_ROWS; r++) begin
			limit += n_pops[r] * 20;
		end
	endtask

	// steps the program architecturally, one entry per expected pop
	task automatic build_expected(input int r);
		pc_t pc;
		pc_t nxt;
		pc_t off;
		pc_t ras [$];
		instr_t i;
		int w;
		int bi;
		bit pred;
		bit tk;
		pc = RESET_PC;
		bi = 0;
		for (int k = 0; k < n_pops[r]; k++) begin
			w = int'((pc - RESET_PC) >> 2);
			i = prog[r][w];
			exp_pc[k] = pc;
			exp_instr[k] = i;
			exp_is_br[k] = 1'b0;
			exp_taken[k] = 1'b0;
			exp_mis[k] = 1'b0;
			nxt = pc + 64'd4;
			if (i[6:0] == 7'b1101111) begin
				if (is_link(i[11:7])) begin
					ras.push_back(pc + 64'd4);
				end
				nxt = pc + jump_offset(i);
			end else if (i[6:0] == 7'b1100111) begin
				if (is_link(i[19:15]) && i[19:15] != i[11:7] && ras.size() > 0) begin
					nxt = ras.pop_back();
				end else begin
					nxt = row_jalr_pc[r];
				end
				if (is_link(i[11:7])) begin
					ras.push_back(pc + 64'd4);
				end
			end else if (i[6:0] == 7'b1100011) begin
				off = branch_offset(i);
				pred = off[`FETCH_XLEN-1];
				tk = (bi < 8 && ev_given[r][bi]) ? ev_taken[r][bi] : pred;
				exp_is_br[k] = 1'b1;
				exp_taken[k] = tk;
				exp_mis[k] = (tk != pred);
				nxt = tk ? pc + off : pc + 64'd4;
				bi++;
			end
			pc = nxt;
		end
	endtask

	initial begin
		int k;
		bit mis_exp;
		void'($urandom(30));
		cycles = 0;
		limit = 1000;
		rst_n = 1'b0;
		load_we = 1'b0;
		load_addr = '0;
		load_data = '0;
		jalr_valid = 1'b0;
		jalr_pc = '0;
		bru_valid = 1'b0;
		bru_taken = 1'b0;
		ifq_pop = 1'b0;
		fill_table();
		for (int r = 0; r < N_ROWS; r++) begin
			build_expected(r);
			pending.delete();
			@(negedge CLK);
			rst_n = 1'b0;
			jalr_pc = row_jalr_pc[r];
			// program goes in while the core is held in reset
			for (int w = 0; w < 8; w++) begin
				load_we = 1'b1;
				load_addr = itcm_addr_t'(w);
				load_data = prog[r][w];
				@(negedge CLK);
			end
			load_we = 1'b0;
			repeat (2) @(negedge CLK);
			rst_n = 1'b1;
			k = 0;
			while (k < n_pops[r]) begin
				@(negedge CLK);
				ifq_pop = 1'b0;
				bru_valid = 1'b0;
				mis_exp = 1'b0;
				jalr_valid = ($urandom % 4 == 0);
				// wrong target while jalr_valid is low
				jalr_pc = jalr_valid ? row_jalr_pc[r] : row_jalr_pc[r] + 64'h4;
				load_we = 1'b0;
				if (stress[r] && $urandom % 6 == 0) begin
					// upper half of the itcm holds no program
					load_we = 1'b1;
					load_addr = itcm_addr_t'(14'h2000 | ($urandom % 4096));
					load_data = $urandom;
				end
				if (ifq_valid && (!stress[r] || $urandom % 4 != 0)) begin
					check_pc(row_name[r], exp_pc[k], ifq_pc);
					check_instr(row_name[r], exp_instr[k], ifq_instr);
					ifq_pop = 1'b1;
					if (exp_is_br[k] && hold_bru[r]) begin
						pending.push_back(exp_taken[k]);
					end else if (exp_is_br[k]) begin
						bru_valid = 1'b1;
						bru_taken = exp_taken[k];
						mis_exp = exp_mis[k];
					end
					k++;
				end
				if (hold_bru[r] && pending.size() >= 16) begin
					bru_valid = 1'b1;
					bru_taken = pending.pop_front();
				end
				#5;
				check_mispredict(row_name[r], mis_exp, mispredict);
			end
			@(negedge CLK);
			ifq_pop = 1'b0;
			bru_valid = 1'b0;
			jalr_valid = 1'b0;
			load_we = 1'b0;
		end
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== fetch_unit.f ====
+incdir+logic
logic/fetch_pkg.sv
logic/sync_fifo.sv
logic/return_stack.sv
logic/itcm.sv
logic/itcm_arbiter.sv
logic/pc_generate.sv
logic/fetch_unit.sv
verif/fetch_unit_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = fetch_unit_tb
FILELIST = fetch_unit.f
OBJDIR = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
